//--- compile.f
serial_pkg.sv
serial_state.sv
serial_decode.sv
serial_bufreg.sv
serial_ctrl.sv
serial_alu.sv
serial_regfile.sv
serial_mem_if.sv
serial_core.sv
tb_serial_core.sv

//--- serial_alu.sv
`default_nettype none

module serial_alu (
   input  wire       clk,
   input  wire       i_rst_n,
   input  wire       i_en,
   input  wire       i_init,
   input  wire       i_rs1,
   input  wire       i_op_b,
   input  wire       i_sub,
   input  wire [1:0] i_bool_op,
   input  wire       i_rd_sel,
   output logic      o_rd,
   output logic      o_eq
);

   import serial_pkg::*;

   logic en_q;
   logic carry;
   logic cin;
   logic b;
   logic sum;
   logic bool_bit;

   // Carry is preset on the first bit of a subtract
   assign cin = en_q ? carry : i_sub;
   assign b   = i_op_b ^ i_sub;
   assign sum = i_rs1 ^ b ^ cin;

   always_comb begin
      case (i_bool_op)
         BOOL_XOR: bool_bit = i_rs1 ^ i_op_b;
         BOOL_OR:  bool_bit = i_rs1 | i_op_b;
         BOOL_AND: bool_bit = i_rs1 & i_op_b;
         default:  bool_bit = i_op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         en_q  <= 1'b0;
         carry <= 1'b0;
         o_eq  <= 1'b0;
      end else begin
         en_q <= i_en;
         if (i_en) begin
            carry <= (i_rs1 & b) | (i_rs1 & cin) | (b & cin);
         end
         // Compare only in the address pass and hold the flag for the PC pass
         if (i_en && i_init) begin
            o_eq <= (o_eq || !en_q) && !(i_rs1 ^ i_op_b);
         end
      end
   end

   assign o_rd = (i_rd_sel == RD_SEL_BOOL) ? bool_bit : sum;

endmodule

`default_nettype wire

//--- serial_bufreg.sv
`default_nettype none

module serial_bufreg (
   input  wire                         clk,
   input  wire                         i_rst_n,
   input  wire                         i_en,
   input  wire                         i_rs1,
   input  wire                         i_imm,
   input  wire                         i_use_rs1,
   input  wire [serial_pkg::CNT_W-1:0] i_cnt,
   output logic                        o_q,
   output logic [31:0]                 o_adr
);

   logic [31:0] q;
   logic        carry;
   logic        cin;
   logic        a;
   logic        sum;

   // Branches only stage their offset here
   assign a   = i_use_rs1 && i_rs1;
   assign cin = (i_cnt == '0) ? 1'b0 : carry;
   assign sum = a ^ i_imm ^ cin;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry <= 1'b0;
      end else if (i_en) begin
         carry <= (a & i_imm) | (a & cin) | (i_imm & cin);
      end
   end

   always_ff @(posedge clk) begin
      if (i_en) begin
         q <= {sum, q[31:1]};
      end
   end

   assign o_q   = q[0];
   assign o_adr = {q[31:2], 2'b00};

endmodule

`default_nettype wire

//--- serial_core.sv
`default_nettype none

module serial_core (
   input  wire         clk,
   input  wire         i_rst_n,
   output logic [31:0] o_ibus_adr,
   output logic        o_ibus_cyc,
   input  wire [31:0]  i_ibus_rdt,
   input  wire         i_ibus_ack,
   output logic [31:0] o_dbus_adr,
   output logic [31:0] o_dbus_dat,
   output logic        o_dbus_we,
   output logic        o_dbus_cyc,
   input  wire [31:0]  i_dbus_rdt,
   input  wire         i_dbus_ack
);

   import serial_pkg::*;

   logic [CNT_W-1:0] cnt;
   logic             cnt_en;
   logic             cnt_done;
   logic             init;
   logic             pc_en;
   logic             rd_en_phase;

   logic [4:0]       rs1_addr;
   logic [4:0]       rs2_addr;
   logic [4:0]       rd_addr;
   logic             rd_write;
   logic             imm;
   logic             op_b_imm;
   logic             alu_sub;
   logic [1:0]       alu_bool_op;
   logic             alu_rd_sel;
   logic             mem_op;
   logic             branch_op;
   logic             take_branch;
   logic             jal;
   logic             alu_eq;

   logic             rs1;
   logic             rs2;
   logic             buf_q;
   logic             alu_rd;
   logic             ctrl_rd;
   logic             mem_rd;
   logic             rd;

   serial_state u_state (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_ibus_ack    (i_ibus_ack),
      .i_dbus_ack    (i_dbus_ack),
      .i_mem_op      (mem_op),
      .i_branch_op   (branch_op),
      .o_ibus_cyc    (o_ibus_cyc),
      .o_dbus_cyc    (o_dbus_cyc),
      .o_init        (init),
      .o_cnt_en      (cnt_en),
      .o_cnt         (cnt),
      .o_cnt_done    (cnt_done),
      .o_pc_en       (pc_en),
      .o_rd_en_phase (rd_en_phase)
   );

   serial_decode u_decode (
      .clk           (clk),
      .i_ibus_ack    (i_ibus_ack),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_cnt_en      (cnt_en),
      .i_cnt         (cnt),
      .i_alu_eq      (alu_eq),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_rd_addr     (rd_addr),
      .o_rd_write    (rd_write),
      .o_imm         (imm),
      .o_op_b_imm    (op_b_imm),
      .o_sub         (alu_sub),
      .o_bool_op     (alu_bool_op),
      .o_rd_sel      (alu_rd_sel),
      .o_mem_op      (mem_op),
      .o_mem_we      (o_dbus_we),
      .o_branch_op   (branch_op),
      .o_take_branch (take_branch),
      .o_jal         (jal)
   );

   serial_bufreg u_bufreg (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_en      (cnt_en),
      .i_rs1     (rs1),
      .i_imm     (imm),
      .i_use_rs1 (mem_op),
      .i_cnt     (cnt),
      .o_q       (buf_q),
      .o_adr     (o_dbus_adr)
   );

   serial_ctrl u_ctrl (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_pc_en    (pc_en),
      .i_cnt_en   (cnt_en),
      .i_cnt_done (cnt_done),
      .i_jump     (jal | take_branch),
      .i_imm      (imm),
      .i_buf      (buf_q),
      .i_jal      (jal),
      .o_ibus_adr (o_ibus_adr),
      .o_rd       (ctrl_rd)
   );

   serial_alu u_alu (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_en      (cnt_en),
      .i_init    (init),
      .i_rs1     (rs1),
      .i_op_b    (op_b_imm ? imm : rs2),
      .i_sub     (alu_sub),
      .i_bool_op (alu_bool_op),
      .i_rd_sel  (alu_rd_sel),
      .o_rd      (alu_rd),
      .o_eq      (alu_eq)
   );

   serial_regfile u_regfile (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_wen   (rd_write & rd_en_phase),
      .i_rd       (rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serial_mem_if u_mem_if (
      .clk        (clk),
      .i_en       (cnt_en),
      .i_dbus_ack (i_dbus_ack),
      .i_dbus_rdt (i_dbus_rdt),
      .i_rs2      (rs2),
      .o_dbus_dat (o_dbus_dat),
      .o_rd       (mem_rd)
   );

   // Link value, load data or ALU result
   assign rd = jal ? ctrl_rd : (mem_op ? mem_rd : alu_rd);

endmodule

`default_nettype wire

//--- serial_ctrl.sv
`default_nettype none

module serial_ctrl (
   input  wire         clk,
   input  wire         i_rst_n,
   input  wire         i_pc_en,
   input  wire         i_cnt_en,
   input  wire         i_cnt_done,
   input  wire         i_jump,
   input  wire         i_imm,
   input  wire         i_buf,
   input  wire         i_jal,
   output logic [31:0] o_ibus_adr,
   output logic        o_rd
);

   import serial_pkg::*;

   logic [31:0] pc;
   // Marks bit 2 for the +4 addend
   logic [2:0]  four_sh;
   logic        c4;
   logic        cj;
   logic        off;
   logic        sum4;
   logic        sumj;
   logic        new_bit;

   assign off  = i_jal ? i_imm : i_buf;
   assign sum4 = pc[0] ^ four_sh[0] ^ c4;
   assign sumj = pc[0] ^ off ^ cj;

   assign new_bit = i_jump ? sumj : sum4;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc      <= RESET_PC;
         four_sh <= 3'b100;
         c4      <= 1'b0;
         cj      <= 1'b0;
      end else if (i_cnt_en) begin
         // PC rotates back into place when it is not updated
         pc      <= {i_pc_en ? new_bit : pc[0], pc[31:1]};
         four_sh <= i_cnt_done ? 3'b100 : {1'b0, four_sh[2:1]};
         if (i_cnt_done) begin
            c4 <= 1'b0;
            cj <= 1'b0;
         end else if (i_pc_en) begin
            c4 <= pc[0] & four_sh[0] | c4 & (pc[0] ^ four_sh[0]);
            cj <= pc[0] & off | cj & (pc[0] ^ off);
         end
      end
   end

   assign o_ibus_adr = pc;
   // Link value for JAL
   assign o_rd       = sum4;

endmodule

`default_nettype wire

//--- serial_decode.sv
`default_nettype none

module serial_decode (
   input  wire                          clk,
   input  wire                          i_ibus_ack,
   input  wire [31:0]                   i_ibus_rdt,
   input  wire                          i_cnt_en,
   input  wire [serial_pkg::CNT_W-1:0]  i_cnt,
   input  wire                          i_alu_eq,
   output logic [4:0]                   o_rs1_addr,
   output logic [4:0]                   o_rs2_addr,
   output logic [4:0]                   o_rd_addr,
   output logic                         o_rd_write,
   output logic                         o_imm,
   output logic                         o_op_b_imm,
   output logic                         o_sub,
   output logic [1:0]                   o_bool_op,
   output logic                         o_rd_sel,
   output logic                         o_mem_op,
   output logic                         o_mem_we,
   output logic                         o_branch_op,
   output logic                         o_take_branch,
   output logic                         o_jal
);

   import serial_pkg::*;

   logic [31:0] ir;
   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic        is_lui;
   logic        imm_bit;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         ir <= i_ibus_rdt;
      end
   end

   assign opcode = ir[6:0];
   assign funct3 = ir[14:12];

   assign o_rs1_addr = ir[19:15];
   assign o_rs2_addr = ir[24:20];
   assign o_rd_addr  = ir[11:7];

   assign is_lui      = (opcode == OP_LUI);
   assign o_jal       = (opcode == OP_JAL);
   assign o_branch_op = (opcode == OP_BRANCH);
   assign o_mem_op    = ((opcode == OP_LOAD) || (opcode == OP_STORE)) && (funct3 == F3_WORD);
   assign o_mem_we    = (opcode == OP_STORE);

   assign o_rd_write = ((opcode == OP_IMM) || (opcode == OP_REG) || is_lui || o_jal ||
                        (opcode == OP_LOAD)) && (o_rd_addr != 5'd0);

   assign o_op_b_imm = (opcode != OP_REG) && !o_branch_op;
   assign o_sub      = (opcode == OP_REG) && ir[30];

   always_comb begin
      if (is_lui) begin
         o_bool_op = BOOL_PASS;
      end else begin
         case (funct3)
            F3_OR:   o_bool_op = BOOL_OR;
            F3_AND:  o_bool_op = BOOL_AND;
            default: o_bool_op = BOOL_XOR;
         endcase
      end
   end

   assign o_rd_sel = (is_lui || (funct3 != F3_ADD)) ? RD_SEL_BOOL : RD_SEL_ADD;

   assign o_take_branch = o_branch_op && (((funct3 == F3_BEQ) && i_alu_eq) ||
                                          ((funct3 == F3_BNE) && !i_alu_eq));

   // Immediate bit for the current count with the sign bit above the field
   always_comb begin
      imm_bit = 1'b0;
      case (opcode)
         OP_STORE: begin
            if (i_cnt < 5)
               imm_bit = ir[7 + i_cnt];
            else if (i_cnt < 11)
               imm_bit = ir[20 + i_cnt];
            else
               imm_bit = ir[31];
         end
         OP_BRANCH: begin
            if (i_cnt == 0)
               imm_bit = 1'b0;
            else if (i_cnt < 5)
               imm_bit = ir[7 + i_cnt];
            else if (i_cnt < 11)
               imm_bit = ir[20 + i_cnt];
            else if (i_cnt == 11)
               imm_bit = ir[7];
            else
               imm_bit = ir[31];
         end
         OP_LUI: begin
            if (i_cnt >= 12)
               imm_bit = ir[i_cnt];
         end
         OP_JAL: begin
            if (i_cnt == 0)
               imm_bit = 1'b0;
            else if (i_cnt < 11)
               imm_bit = ir[20 + i_cnt];
            else if (i_cnt == 11)
               imm_bit = ir[20];
            else if (i_cnt < 20)
               imm_bit = ir[i_cnt];
            else
               imm_bit = ir[31];
         end
         default: begin
            if (i_cnt < 11)
               imm_bit = ir[20 + i_cnt];
            else
               imm_bit = ir[31];
         end
      endcase
   end

   assign o_imm = i_cnt_en && imm_bit;

endmodule

`default_nettype wire

//--- serial_mem_if.sv
`default_nettype none

module serial_mem_if (
   input  wire         clk,
   input  wire         i_en,
   input  wire         i_dbus_ack,
   input  wire [31:0]  i_dbus_rdt,
   input  wire         i_rs2,
   output logic [31:0] o_dbus_dat,
   output logic        o_rd
);

   logic [31:0] dat;

   // One register serves store data and load data
   always_ff @(posedge clk) begin
      if (i_dbus_ack) begin
         dat <= i_dbus_rdt;
      end else if (i_en) begin
         dat <= {i_rs2, dat[31:1]};
      end
   end

   assign o_dbus_dat = dat;
   assign o_rd       = dat[0];

endmodule

`default_nettype wire

//--- serial_pkg.sv
`default_nettype none

package serial_pkg;

   localparam logic [31:0] RESET_PC = 32'h0000_0000;

   // Base opcodes of the supported subset
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;

   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_WORD = 3'b010;

   localparam logic [1:0] BOOL_XOR  = 2'b00;
   localparam logic [1:0] BOOL_OR   = 2'b01;
   localparam logic [1:0] BOOL_AND  = 2'b10;
   localparam logic [1:0] BOOL_PASS = 2'b11;

   localparam logic RD_SEL_ADD  = 1'b0;
   localparam logic RD_SEL_BOOL = 1'b1;

   localparam int CNT_W = 5;

endpackage

`default_nettype wire

//--- serial_regfile.sv
`default_nettype none

module serial_regfile (
   input  wire                         clk,
   input  wire                         i_cnt_en,
   input  wire [serial_pkg::CNT_W-1:0] i_cnt,
   input  wire [4:0]                   i_rs1_addr,
   input  wire [4:0]                   i_rs2_addr,
   input  wire [4:0]                   i_rd_addr,
   input  wire                         i_rd_wen,
   input  wire                         i_rd,
   output logic                        o_rs1,
   output logic                        o_rs2
);

   logic [31:0] regs [0:31];

   always_ff @(posedge clk) begin
      if (i_cnt_en && i_rd_wen && (i_rd_addr != 5'd0)) begin
         regs[i_rd_addr][i_cnt] <= i_rd;
      end
   end

   assign o_rs1 = (i_rs1_addr == 5'd0) ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr == 5'd0) ? 1'b0 : regs[i_rs2_addr][i_cnt];

endmodule

`default_nettype wire

//--- serial_state.sv
`default_nettype none

module serial_state (
   input  wire                          clk,
   input  wire                          i_rst_n,
   input  wire                          i_ibus_ack,
   input  wire                          i_dbus_ack,
   input  wire                          i_mem_op,
   input  wire                          i_branch_op,
   output logic                         o_ibus_cyc,
   output logic                         o_dbus_cyc,
   output logic                         o_init,
   output logic                         o_cnt_en,
   output logic [serial_pkg::CNT_W-1:0] o_cnt,
   output logic                         o_cnt_done,
   output logic                         o_pc_en,
   output logic                         o_rd_en_phase
);

   import serial_pkg::*;

   typedef enum logic [1:0] {
      PH_FETCH,
      PH_READ,
      PH_RUN,
      PH_DBUS
   } phase_t;

   phase_t phase;
   // Set for the second pass of branches and memory ops
   logic   pass2;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         phase <= PH_FETCH;
         o_cnt <= '0;
         pass2 <= 1'b0;
      end else begin
         case (phase)
            PH_FETCH: begin
               if (i_ibus_ack) begin
                  phase <= PH_READ;
               end
            end
            PH_READ: begin
               phase <= PH_RUN;
            end
            PH_RUN: begin
               o_cnt <= o_cnt + 1'b1;
               if (o_cnt_done) begin
                  if (i_mem_op && !pass2) begin
                     phase <= PH_DBUS;
                  end else if (i_branch_op && !pass2) begin
                     phase <= PH_READ;
                     pass2 <= 1'b1;
                  end else begin
                     phase <= PH_FETCH;
                     pass2 <= 1'b0;
                  end
               end
            end
            default: begin
               // Load data or store completion, then the write-back pass
               if (i_dbus_ack) begin
                  phase <= PH_READ;
                  pass2 <= 1'b1;
               end
            end
         endcase
      end
   end

   assign o_ibus_cyc    = (phase == PH_FETCH);
   assign o_dbus_cyc    = (phase == PH_DBUS);
   assign o_cnt_en      = (phase == PH_RUN);
   assign o_cnt_done    = o_cnt_en && (o_cnt == CNT_W'(31));
   assign o_init        = o_cnt_en && !pass2 && (i_mem_op || i_branch_op);
   // Branches move the PC only once the compare is known
   assign o_pc_en       = o_cnt_en && (i_branch_op ? pass2 : !pass2);
   assign o_rd_en_phase = o_cnt_en && !o_init;

endmodule

`default_nettype wire

//--- serial_stimulus.txt
// One 32-bit hex word per entry. @00 counts of program words, stores and fetches
// @08 program words, @40 expected store address and data pairs, @60 expected fetch addresses
@00
0000001A 00000008 00000017
@08
12300093 12345137 002081B3 40110233
0041C2B3 0041F333 0050E3B3 10200413
FE342F23 00442123 00542323 00642523
00742723 05500013 00042923 00208463
00109463 00108463 00100593 00209463
00100593 008004EF 00100593 FFE42503
00A42B23 00942D23
@40
00000100 12345123
00000104 12344EDD
00000108 00001FFE
0000010C 12344001
00000110 00001FFF
00000114 00000000
00000118 12345123
0000011C 00000058
@60
00000000 00000004 00000008 0000000C 00000010 00000014 00000018 0000001C
00000020 00000024 00000028 0000002C 00000030 00000034 00000038 0000003C
00000040 00000044 0000004C 00000054 0000005C 00000060 00000064

//--- tb_serial_core.sv
`default_nettype none

module tb_serial_core;

   timeunit 1ns;
   timeprecision 100ps;

   import serial_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int STIM_WORDS = 128;
   // Word offsets of the sections in the stimulus file
   localparam int PROG_BASE  = 'h08;
   localparam int STORE_BASE = 'h40;
   localparam int FETCH_BASE = 'h60;
   localparam int PROG_MAX   = STORE_BASE - PROG_BASE;
   localparam int STORE_MAX  = (FETCH_BASE - STORE_BASE) / 2;
   localparam int FETCH_MAX  = STIM_WORDS - FETCH_BASE;

   logic        clk;
   logic        rst_n;
   logic [31:0] ibus_adr;
   logic        ibus_cyc;
   logic [31:0] ibus_rdt;
   logic        ibus_ack;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   logic        dbus_we;
   logic        dbus_cyc;
   logic [31:0] dbus_rdt;
   logic        dbus_ack;

   logic [31:0] stim [0:STIM_WORDS-1];
   logic [31:0] imem [0:63];
   logic [31:0] dmem [0:255];
   logic [31:0] exp_st_adr [0:STORE_MAX-1];
   logic [31:0] exp_st_dat [0:STORE_MAX-1];
   logic [31:0] exp_fetch [0:FETCH_MAX-1];

   int     n_prog = 0;
   int     n_store = 0;
   int     n_fetch = 0;
   int     ibus_wait = -1;
   int     dbus_wait = -1;
   int     fetch_seen = 0;
   int     store_done = 0;
   integer seed = 30;

   serial_core i_serial_core (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_we  (dbus_we),
      .o_dbus_cyc (dbus_cyc),
      .i_dbus_rdt (dbus_rdt),
      .i_dbus_ack (dbus_ack)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "Simulation stopped after a failure");
   endtask

   task automatic check_adr(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         fail_run($sformatf("Error at %0t: %s expected %h, actual %h", $time, name, exp, act));
      end
   endtask

   task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         fail_run($sformatf("Error at %0t: %s expected %h, actual %h", $time, name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_run($sformatf("Error at %0t: %s expected %b, actual %b", $time, name, exp, act));
      end
   endtask

   // Ack latency of 0 to 3 cycles
   function automatic int ack_delay();
      return $unsigned($random(seed)) % 4;
   endfunction

   task automatic load_stimulus();
      int i;
      $readmemh("serial_stimulus.txt", stim);
      n_prog  = stim[0];
      n_store = stim[1];
      n_fetch = stim[2];
      if (n_prog == 0 || n_prog > PROG_MAX || n_store > STORE_MAX || n_fetch > FETCH_MAX) begin
         fail_run("The stimulus file is missing or its counts are out of range");
      end
      // Unused words hold ADDI x0, x0 with their own index
      for (i = 0; i < 64; i++) begin
         imem[i] = (32'(i) << 20) | 32'h0000_0013;
      end
      for (i = 0; i < 256; i++) begin
         dmem[i] = {~16'(i), 16'(i)};
      end
      for (i = 0; i < n_prog; i++) begin
         imem[i] = stim[PROG_BASE + i];
      end
      for (i = 0; i < n_store; i++) begin
         exp_st_adr[i] = stim[STORE_BASE + 2 * i];
         exp_st_dat[i] = stim[STORE_BASE + 2 * i + 1];
      end
      for (i = 0; i < n_fetch; i++) begin
         exp_fetch[i] = stim[FETCH_BASE + i];
      end
   endtask

   // Instruction memory
   always @(posedge clk) begin : ibus_model
      int delay;
      ibus_ack <= 1'b0;
      if (!rst_n) begin
         ibus_wait <= -1;
      end else if (ibus_cyc && !ibus_ack) begin
         delay = (ibus_wait < 0) ? ack_delay() : ibus_wait;
         if (delay == 0) begin
            ibus_ack  <= 1'b1;
            ibus_rdt  <= imem[ibus_adr[7:2]];
            ibus_wait <= -1;
         end else begin
            ibus_wait <= delay - 1;
         end
      end
   end

   // Data memory where stores land on ack
   always @(posedge clk) begin : dbus_model
      int delay;
      dbus_ack <= 1'b0;
      if (!rst_n) begin
         dbus_wait <= -1;
      end else if (dbus_cyc && !dbus_ack) begin
         delay = (dbus_wait < 0) ? ack_delay() : dbus_wait;
         if (delay == 0) begin
            dbus_ack  <= 1'b1;
            dbus_wait <= -1;
            if (dbus_we) begin
               dmem[dbus_adr[9:2]] <= dbus_dat;
               store_done <= store_done + 1;
            end else begin
               dbus_rdt <= dmem[dbus_adr[9:2]];
            end
         end else begin
            dbus_wait <= delay - 1;
         end
      end
   end

   // New fetch requests against the expected address sequence
   always @(posedge clk) begin
      if (rst_n && ibus_cyc && !ibus_ack && ibus_wait < 0) begin
         if (fetch_seen >= n_fetch) begin
            fail_run($sformatf("Fetch from %h is beyond the expected sequence", ibus_adr));
         end else begin
            check_adr("o_ibus_adr", exp_fetch[fetch_seen], ibus_adr);
         end
         fetch_seen <= fetch_seen + 1;
      end
   end

   always @(posedge clk) begin
      if (rst_n && dbus_cyc && !dbus_ack && dbus_wait < 0) begin
         // The last fetched word is a store or a load
         check_flag("o_dbus_we", ibus_rdt[6:0] == OP_STORE, dbus_we);
         if (dbus_we) begin
            if (store_done >= n_store) begin
               fail_run($sformatf("Store to %h was not expected", dbus_adr));
            end else begin
               check_adr("o_dbus_adr", exp_st_adr[store_done], dbus_adr);
               check_data("o_dbus_dat", exp_st_dat[store_done], dbus_dat);
            end
         end
      end
   end

   initial begin : watchdog
      wait (n_prog > 0);
      #(n_prog * 100 * CLK_PERIOD);
      fail_run($sformatf("Timeout, the program did not finish within %0d cycles",
                         n_prog * 100));
   end

   initial begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      ibus_rdt = '0;
      ibus_ack = 1'b0;
      dbus_rdt = '0;
      dbus_ack = 1'b0;
      load_stimulus();
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      check_flag("o_dbus_cyc", 1'b0, dbus_cyc);
      check_flag("o_ibus_cyc", 1'b1, ibus_cyc);
      check_adr("o_ibus_adr", RESET_PC, ibus_adr);
      while (store_done < n_store) begin
         @(posedge clk);
      end
      if (fetch_seen != n_fetch) begin
         fail_run($sformatf("Saw %0d fetches where %0d were expected", fetch_seen, n_fetch));
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire
